/* verilog.f */
+incdir+hdl
hdl/tiled_pkg.sv
hdl/tiled_regs.sv
hdl/tiled_addr_calc.sv
hdl/tiled_span_calc.sv
hdl/tiled_sequencer.sv
hdl/tiled_rw_top.sv
testbench/tiled_rw_assertions.sv
testbench/tiled_rw_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tiled_rw_tb
FLIST     = verilog.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)

/* testbench/tiled_rw_tb.sv */
`timescale 1ns/1ps
`include "tiled_config.svh"

module tiled_rw_tb;
    import tiled_pkg::*;

    logic    rst;              // clock
    logic    mclk;             // reset
    cmd_t    cmd;
    logic    frame_start;
    logic    next_page;
    logic    np_auto;          // page responder returns the page
    logic    np_man;           // manual next_page pulses
    logic    xfer_grant;
    logic    xfer_page_done;
    logic    xfer_want;
    logic    xfer_need;
    logic    xfer_start;
    xfer_t   xfer;
    logic    frame_done;

    int      seed = 53995;
    int      errors = 0;
    int      nstart = 0;       // starts in the current frame
    int      np_starts = 0;    // non-partial starts in the current frame
    int      partials = 0;
    int      fd_count = 0;
    int      owed = 0;         // page_done pulses still due
    int      compared = 0;
    bit      grant_on = 1;
    bit      auto_pages = 1;
    int      sa, ffw, ww, wh, x0, y0, sx, sy, tc, tr, vs;  // model window
    bit      ko;

    assign next_page = np_auto | np_man;

    tiled_rw_top dut0 (
        .rst(rst), .mclk(mclk), .cmd(cmd), .frame_start(frame_start),
        .next_page(next_page), .xfer_grant(xfer_grant), .xfer_page_done(xfer_page_done),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer(xfer), .frame_done(frame_done)
    );

    initial begin
        rst = 1'b0;
        forever #5 rst = ~rst;
    end

    // walks the window tile by tile, returns the n-th transfer and the total
    function automatic xfer_t model_xfer(input int n, output int total);
        int    x, y, left, idx, row_left, span, fx, fy, rc, page_left, cols;
        bit    cont, part, lir, lr, done;
        xfer_t r, e;
        x = sx;
        y = sy;
        cont = 0;
        left = 0;
        idx = 0;
        done = 0;
        r = '0;
        while (!done && idx < 1000) begin
            row_left = ww - x;
            span = (tc < row_left) ? tc : row_left;  // clipped at window edge
            lir = (row_left == span);
            lr = (y + vs) > (wh - tr);
            fx = x0 + x;
            fy = y0 + y;
            rc = (sa + (fy >> 3) * ffw + fx) & 32'h3fffff;  // {row, col} wraps at 22 bits
            page_left = 128 - (rc & 127);
            part = 0;
            if (cont) cols = left;                 // second half of a split tile
            else if (page_left < span) begin
                cols = page_left;
                part = 1;
                left = span - page_left;
            end else cols = span;
            e.addr.bank = 3'(fy & 7);
            e.addr.row = 15'(rc >> 7);
            e.addr.col = 7'(rc & 127);
            e.num_cols_m1 = 6'(cols - 1);
            e.num_rows_m1 = 6'(tr - 1);
            e.rowcol_inc = 14'(ffw);
            e.keep_open = ko;
            e.partial = part;
            if (idx == n) r = e;
            idx++;
            if (!part && lir) begin
                if (lr) done = 1;                  // last block
                x = 0;
                y = y + vs;
            end else x = x + cols;
            cont = part;
        end
        total = idx;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] e, input logic [31:0] a);
        assert (e == a) else begin
            $display("MISMATCH %s start %0d: expected %h actual %h", name, nstart, e, a);
            errors++;
        end
    endtask

    // compare every start against the model
    initial begin : compare
        xfer_t exp;
        int    total;
        forever begin
            @(negedge rst);
            if (frame_done) fd_count++;
            if (xfer_start) begin
                exp = model_xfer(nstart, total);
                assert (nstart < total) else begin
                    $display("start %0d beyond the %0d transfers of the frame", nstart, total);
                    errors++;
                end
                check_field("xfer.addr.bank", 32'(exp.addr.bank), 32'(xfer.addr.bank));
                check_field("xfer.addr.row", 32'(exp.addr.row), 32'(xfer.addr.row));
                check_field("xfer.addr.col", 32'(exp.addr.col), 32'(xfer.addr.col));
                check_field("xfer.num_cols_m1", 32'(exp.num_cols_m1), 32'(xfer.num_cols_m1));
                check_field("xfer.num_rows_m1", 32'(exp.num_rows_m1), 32'(xfer.num_rows_m1));
                check_field("xfer.rowcol_inc", 32'(exp.rowcol_inc), 32'(xfer.rowcol_inc));
                check_field("xfer.keep_open", 32'(exp.keep_open), 32'(xfer.keep_open));
                check_field("xfer.partial", 32'(exp.partial), 32'(xfer.partial));
                compared++;
                nstart++;
                if (xfer.partial) partials++;
                else begin
                    np_starts++;
                    owed++;                        // memory side owes a page_done
                end
            end
        end
    end

    // grant after a random 0..3 cycle delay
    initial begin : grant_responder
        int d;
        forever begin
            @(negedge rst);
            if (grant_on && xfer_want) begin
                d = {$random(seed)} % 4;
                repeat (d) @(negedge rst);
                if (grant_on && xfer_want) begin
                    xfer_grant = 1'b1;
                    @(negedge rst);
                    xfer_grant = 1'b0;
                end
            end
        end
    end

    // one page_done per non-partial start, a few cycles later
    initial begin : page_responder
        int d;
        forever begin
            @(negedge rst);
            if (owed > 0) begin
                d = 2 + {$random(seed)} % 4;
                repeat (d) @(negedge rst);
                owed--;
                xfer_page_done = 1'b1;
                np_auto = auto_pages;              // buffer frees the page at once
                @(negedge rst);
                xfer_page_done = 1'b0;
                np_auto = 1'b0;
            end
        end
    end

    task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
        @(negedge rst);
        cmd = '{wr: 1'b1, addr: a, data: d};
        @(negedge rst);
        cmd = '0;
    endtask

    task automatic setup_window(input int w, input int h, input int wx, input int wy,
                                input int c, input int r, input bit keep);
        sa = 32'h200;
        ffw = 256;
        ww = w;
        wh = h;
        x0 = wx;
        y0 = wy;
        sx = 0;
        sy = 0;
        tc = c;
        tr = r;
        vs = r;                                    // no overlap between tile rows
        ko = keep;
        write_reg(`TILED_STARTADDR, 32'(sa));
        write_reg(`TILED_FRAME_FULL_WIDTH, 32'(ffw));
        write_reg(`TILED_WINDOW_WH, 32'((wh << 16) | ww));
        write_reg(`TILED_WINDOW_X0Y0, 32'((y0 << 16) | x0));
        write_reg(`TILED_WINDOW_STARTXY, 32'((sy << 16) | sx));
        write_reg(`TILED_TILE_WHS, 32'((vs << 16) | (tr << 8) | tc));
        write_reg(`TILED_MODE, keep ? 32'h13 : 32'h03);  // enabled, out of reset
    endtask

    task automatic begin_frame;
        @(negedge rst);
        nstart = 0;
        np_starts = 0;
        partials = 0;
        fd_count = 0;
        frame_start = 1'b1;
        @(negedge rst);
        frame_start = 1'b0;
    endtask

    // client hands back n buffer pages, one pulse each
    task automatic return_pages(input int n);
        repeat (n) begin
            @(negedge rst);
            np_man = 1'b1;
            @(negedge rst);
            np_man = 1'b0;
        end
    endtask

    task automatic wait_frame_done(input int limit);
        int n;
        n = 0;
        while (fd_count == 0 && n < limit) begin
            @(negedge rst);
            n++;
        end
        assert (fd_count > 0) else begin
            $display("timeout: frame_done never came within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic wait_np_starts(input int target, input int limit);
        int n;
        n = 0;
        while (np_starts < target && n < limit) begin
            @(negedge rst);
            n++;
        end
        assert (np_starts >= target) else begin
            $display("timeout: only %0d of %0d page starts seen", np_starts, target);
            errors++;
        end
    endtask

    // need on the next want follows the free page count, 3 or more
    task automatic check_need_at_want(input bit exp_need, input int limit);
        int n;
        n = 0;
        while (!xfer_want && n < limit) begin
            @(negedge rst);
            n++;
        end
        assert (xfer_want) else begin
            $display("timeout: xfer_want never rose within %0d cycles", limit);
            errors++;
        end
        if (xfer_want) begin
            assert (xfer_need === exp_need) else begin
                $display("MISMATCH xfer_need: expected %h actual %h", exp_need, xfer_need);
                errors++;
            end
        end
    endtask

    task automatic expect_quiet(input int cycles, input bit want_only);
        bit bad;
        bad = 0;
        repeat (cycles) begin
            @(negedge rst);
            if (xfer_want !== 1'b0 || xfer_start !== 1'b0) bad = 1;
            if (!want_only && (xfer_need !== 1'b0 || frame_done !== 1'b0)) bad = 1;
        end
        assert (!bad) else begin
            $display("handshake outputs went active while the channel should be idle");
            errors++;
        end
    endtask

    task automatic frame_end_checks;
        int total;
        void'(model_xfer(0, total));
        expect_quiet(40, 1);                       // stays idle until the next frame_start
        assert (fd_count == 1) else begin
            $display("frame_done pulsed %0d times instead of once", fd_count);
            errors++;
        end
        assert (nstart == total) else begin
            $display("frame had %0d starts, model expects %0d", nstart, total);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s: %s", name, (errors == err0) ? "ok" : "failed");
    endtask

    initial begin : main
        int e0;
        mclk = 1'b1;
        cmd = '0;
        frame_start = 1'b0;
        np_auto = 1'b0;
        np_man = 1'b0;
        xfer_grant = 1'b0;
        xfer_page_done = 1'b0;
        repeat (3) @(negedge rst);
        mclk = 1'b0;

        e0 = errors;
        expect_quiet(20, 0);                       // idle out of reset
        report("reset_idle", e0);

        e0 = errors;
        setup_window(32, 24, 0, 0, 16, 8, 1);
        begin_frame();
        check_need_at_want(1'b1, 100);             // all 4 pages free
        wait_frame_done(3000);
        report("address_sequence", e0);
        e0 = errors;
        frame_end_checks();
        report("frame_end", e0);

        e0 = errors;
        auto_pages = 0;                            // pages held back, partials cost none
        setup_window(48, 16, 120, 3, 16, 8, 0);   // first tile crosses a page
        begin_frame();
        wait_np_starts(4, 500);
        auto_pages = 1;
        return_pages(4);
        wait_frame_done(3000);
        frame_end_checks();
        assert (partials >= 2) else begin
            $display("only %0d partial transfers seen for a split window", partials);
            errors++;
        end
        report("page_split", e0);

        e0 = errors;
        auto_pages = 0;
        setup_window(128, 16, 0, 0, 16, 8, 0);
        begin_frame();
        wait_np_starts(4, 500);
        expect_quiet(60, 1);                       // no credits left
        return_pages(1);
        check_need_at_want(1'b0, 50);              // a single free page
        wait_np_starts(5, 200);
        expect_quiet(60, 1);
        assert (np_starts == 5) else begin
            $display("one next_page let %0d starts through", np_starts - 4);
            errors++;
        end
        auto_pages = 1;
        return_pages(4);
        wait_frame_done(5000);
        frame_end_checks();
        report("credits", e0);

        e0 = errors;
        begin_frame();
        wait_np_starts(2, 500);
        grant_on = 0;
        repeat (5) @(negedge rst);
        write_reg(`TILED_MODE, 32'h01);            // enable cleared, reset_n kept
        repeat (3) @(negedge rst);
        expect_quiet(40, 0);
        report("disable", e0);

        $display("checks done: %0d errors, %0d starts compared", errors, compared);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* testbench/tiled_rw_assertions.sv */
`timescale 1ns/1ps

module tiled_rw_assertions (
    input logic rst,          // clock
    input logic mclk,         // async reset
    input logic xfer_grant,
    input logic xfer_want,
    input logic xfer_need,
    input logic xfer_start,
    input logic frame_done
);
    // a start always follows a grant by one cycle
    start_after_grant: assert property (@(posedge rst) disable iff (mclk)
        xfer_start |-> $past(xfer_grant))
        else $error("xfer_start without xfer_grant in the prior cycle");

    need_implies_want: assert property (@(posedge rst) disable iff (mclk)
        xfer_need |-> xfer_want)
        else $error("xfer_need high while xfer_want is low");

    frame_done_single: assert property (@(posedge rst) disable iff (mclk)
        frame_done |=> !frame_done)   // one cycle pulse
        else $error("frame_done wider than one cycle");

endmodule

bind tiled_sequencer tiled_rw_assertions chk0 (
    .rst(rst), .mclk(mclk), .xfer_grant(xfer_grant), .xfer_want(xfer_want),
    .xfer_need(xfer_need), .xfer_start(xfer_start), .frame_done(frame_done)
);

/* hdl/tiled_rw_top.sv */
`timescale 1ns/1ps

module tiled_rw_top (
    input  logic             rst,             // clock
    input  logic             mclk,            // async reset
    input  tiled_pkg::cmd_t  cmd,
    input  logic             frame_start,
    input  logic             next_page,
    input  logic             xfer_grant,
    input  logic             xfer_page_done,
    output logic             xfer_want,
    output logic             xfer_need,
    output logic             xfer_start,
    output tiled_pkg::xfer_t xfer,
    output logic             frame_done
);
    import tiled_pkg::*;

    tiled_cfg_t cfg;
    logic       cfg_wr;
    tile_pos_t  pos;
    tile_addr_t addr;
    tile_span_t span;
    logic       recalc;

    tiled_regs regs0 (.rst(rst), .mclk(mclk), .cmd(cmd), .cfg(cfg), .cfg_wr(cfg_wr));

    tiled_addr_calc addr0 (
        .rst(rst), .mclk(mclk), .cfg(cfg), .pos(pos), .recalc(recalc), .addr(addr)
    );

    tiled_span_calc span0 (
        .rst(rst), .mclk(mclk), .cfg(cfg), .pos(pos), .recalc(recalc), .span(span)
    );

    tiled_sequencer seq0 (
        .rst(rst), .mclk(mclk), .cfg(cfg), .cfg_wr(cfg_wr), .addr(addr), .span(span),
        .frame_start(frame_start), .next_page(next_page), .xfer_grant(xfer_grant),
        .xfer_page_done(xfer_page_done), .pos(pos), .recalc(recalc),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer(xfer), .frame_done(frame_done)
    );

endmodule

/* hdl/tiled_sequencer.sv */
`timescale 1ns/1ps
`include "tiled_config.svh"

module tiled_sequencer (
    input  logic                  rst,        // clock
    input  logic                  mclk,       // async reset
    input  tiled_pkg::tiled_cfg_t cfg,
    input  logic                  cfg_wr,
    input  tiled_pkg::tile_addr_t addr,
    input  tiled_pkg::tile_span_t span,
    input  logic                  frame_start,
    input  logic                  next_page,  // client freed one buffer page
    input  logic                  xfer_grant,
    input  logic                  xfer_page_done,
    output tiled_pkg::tile_pos_t  pos,
    output logic                  recalc,
    output logic                  xfer_want,
    output logic                  xfer_need,
    output logic                  xfer_start,
    output tiled_pkg::xfer_t      xfer,
    output logic                  frame_done
);
    import tiled_pkg::*;

    localparam int PW = `COLADDR_NUMBER - 2;  // page_left needs 128

    xfer_t                      xfer_next;   // offered on the next grant
    logic                       chn_en;
    logic                       en_d;
    logic                       trig;        // invalidates calculated results
    logic [`CALC_LATENCY-1:0]   vld_sr;      // restarts on every trigger
    logic                       vld_r;
    logic                       calc_valid;
    logic [PW-1:0]              page_left;   // 8-bursts to the page end, 1..128
    logic                       split;       // tile crosses the page
    logic [`MAX_TILE_WIDTH:0]   cols;
    logic [`MAX_TILE_WIDTH:0]   sent;        // width of the transfer now starting
    logic                       continued;   // second half of a split tile
    logic [`MAX_TILE_WIDTH-1:0] leftover;
    logic                       busy;
    logic                       last_block;
    logic [2:0]                 credits;     // free client buffer pages
    logic [2:0]                 pending;     // non-partial starts not yet done
    logic                       start_np;
    logic                       pre_want;

    assign chn_en     = cfg.enable & cfg.reset_n;
    // frame_start reloads the position, so the results restart too
    assign trig       = xfer_start | cfg_wr | frame_start | (chn_en & ~en_d);
    assign calc_valid = (vld_r | vld_sr[`CALC_LATENCY-1]) & ~trig;
    assign page_left  = {1'b1, {(PW-1){1'b0}}} - PW'(addr.col);
    assign split      = ~continued && (page_left < PW'(span.span));
    assign cols       = continued ? {1'b0, leftover}
                      : split     ? page_left[`MAX_TILE_WIDTH:0] : span.span;
    assign sent       = {1'b0, xfer.num_cols_m1} + 1'b1;
    assign start_np   = xfer_start & ~xfer.partial;  // partial halves use no page
    assign pre_want   = chn_en & busy & calc_valid & ~last_block & ~xfer_start;

    always_comb begin
        xfer_next.addr        = addr;
        xfer_next.num_cols_m1 = `MAX_TILE_WIDTH'(cols - 1'b1);
        xfer_next.num_rows_m1 = `MAX_TILE_HEIGHT'(cfg.tile_rows - 1'b1);
        xfer_next.rowcol_inc  = cfg.frame_full_width;
        xfer_next.keep_open   = cfg.keep_open;
        xfer_next.partial     = split;
    end

    always_ff @(posedge rst) begin
        if (xfer_grant) begin
            xfer     <= xfer_next;  // held through xfer_start
            leftover <= `MAX_TILE_WIDTH'(span.span - page_left[`MAX_TILE_WIDTH:0]);
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            en_d       <= 1'b0;
            recalc     <= 1'b0;
            vld_sr     <= '0;
            vld_r      <= 1'b0;
            busy       <= 1'b0;
            xfer_start <= 1'b0;
            xfer_want  <= 1'b0;
            xfer_need  <= 1'b0;
            continued  <= 1'b0;
            last_block <= 1'b0;
            credits    <= '0;
            pending    <= '0;
            frame_done <= 1'b0;
            pos        <= '0;
        end else begin
            en_d   <= chn_en;
            recalc <= trig;  // a cycle later, once pos and cfg have settled
            vld_sr <= trig ? '0 : {vld_sr[`CALC_LATENCY-2:0], recalc};
            if (trig || recalc)                vld_r <= 1'b0;
            else if (vld_sr[`CALC_LATENCY-1]) vld_r <= 1'b1;

            if (!chn_en)          busy <= 1'b0;
            else if (frame_start) busy <= 1'b1;
            else if (frame_done)  busy <= 1'b0;

            xfer_start <= xfer_grant & chn_en;

            if (!chn_en || xfer_grant) begin
                xfer_want <= 1'b0;
                xfer_need <= 1'b0;
            end else if (pre_want && (credits > {1'b0, cfg.extra_pages})) begin
                xfer_want <= 1'b1;
                if (credits >= 3'd3) xfer_need <= 1'b1;  // buffer nearly drained
            end

            if (frame_start)                 credits <= 3'd4;  // read: all 4 pages free
            else if (start_np && !next_page) credits <= credits - 1'b1;
            else if (!start_np && next_page) credits <= credits + 1'b1;

            if (!chn_en || frame_start) begin
                pos.curr_x <= cfg.start_x;
                pos.curr_y <= cfg.start_y;
            end else if (xfer_start) begin
                if (!xfer.partial && span.last_in_row) begin
                    pos.curr_x <= '0;
                    pos.curr_y <= pos.curr_y + `FRAME_HEIGHT_BITS'(cfg.tile_vstep);
                end else begin
                    pos.curr_x <= pos.curr_x + `FRAME_WIDTH_BITS'(sent);
                end
            end

            if (!chn_en || frame_start) continued <= 1'b0;
            else if (xfer_start)        continued <= xfer.partial;  // only once per split

            if (!chn_en || !busy) last_block <= 1'b0;
            else if (xfer_start)  last_block <= start_np & span.last_in_row & span.last_row;

            if (!chn_en || !busy)                 pending <= '0;
            else if (start_np && !xfer_page_done) pending <= pending + 1'b1;
            else if (!start_np && xfer_page_done) pending <= pending - 1'b1;

            // last page of the last block leaves nothing in flight
            frame_done <= chn_en & busy & last_block & xfer_page_done & ~start_np
                          & (pending == 3'd1);
        end
    end

endmodule

/* hdl/tiled_span_calc.sv */
`timescale 1ns/1ps
`include "tiled_config.svh"

module tiled_span_calc (
    input  logic                  rst,     // clock
    input  logic                  mclk,    // async reset
    input  tiled_pkg::tiled_cfg_t cfg,
    input  tiled_pkg::tile_pos_t  pos,
    input  logic                  recalc,
    output tiled_pkg::tile_span_t span
);
    logic [`CALC_LATENCY-2:0]     stage;     // one-hot, same pacing as the address
    logic [`FRAME_WIDTH_BITS:0]   row_left;  // bursts to the window right edge
    logic [`FRAME_HEIGHT_BITS:0]  next_y;    // top of the next tile row
    logic [`FRAME_HEIGHT_BITS:0]  y_limit;   // last y where a full tile still fits
    logic [`MAX_TILE_WIDTH:0]     lim;       // min(tile_cols, row_left)
    logic                         last_row;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) stage <= '0;
        else      stage <= {stage[`CALC_LATENCY-3:0], recalc};
    end

    always_ff @(posedge rst) begin
        if (recalc) begin
            row_left <= cfg.window_width - (`FRAME_WIDTH_BITS+1)'(pos.curr_x);
            next_y   <= (`FRAME_HEIGHT_BITS+1)'(pos.curr_y)
                        + (`FRAME_HEIGHT_BITS+1)'(cfg.tile_vstep);
            y_limit  <= cfg.window_height - (`FRAME_HEIGHT_BITS+1)'(cfg.tile_rows);
        end
        if (stage[0]) begin
            // anything at or above 64 left is never shorter than a tile
            if ((|row_left[`FRAME_WIDTH_BITS:`MAX_TILE_WIDTH])
                    || (row_left[`MAX_TILE_WIDTH:0] >= cfg.tile_cols))
                lim <= cfg.tile_cols;
            else
                lim <= row_left[`MAX_TILE_WIDTH:0];
            last_row <= next_y > y_limit;  // forgiving of odd window heights
        end
        if (stage[`CALC_LATENCY-2]) begin
            span.span        <= lim;
            span.last_in_row <= row_left == (`FRAME_WIDTH_BITS+1)'(lim);
            span.last_row    <= last_row;
        end
    end

endmodule

/* hdl/tiled_addr_calc.sv */
`timescale 1ns/1ps
`include "tiled_config.svh"

module tiled_addr_calc (
    input  logic                  rst,     // clock
    input  logic                  mclk,    // async reset
    input  tiled_pkg::tiled_cfg_t cfg,
    input  tiled_pkg::tile_pos_t  pos,
    input  logic                  recalc,  // pos and cfg are sampled on this pulse
    output tiled_pkg::tile_addr_t addr
);
    logic [`CALC_LATENCY-2:0]          stage;       // one-hot, walks behind recalc
    logic [`FRAME_WIDTH_BITS-1:0]      frame_x;     // frame relative column
    logic [`FRAME_HEIGHT_BITS-1:0]     frame_y;     // frame relative line
    logic [`FRAME_HEIGHT_BITS-4:0]     frame_y8;    // line without bank bits
    logic [2:0]                        bank;
    logic [`FRAME_WIDTH_BITS+`FRAME_HEIGHT_BITS-3:0] mul_w;  // top bits dropped
    logic [`NUM_RC_BURST_BITS-1:0]     mul_r;
    logic [`NUM_RC_BURST_BITS-1:0]     line_start;  // {row, col8} of line start
    logic [`NUM_RC_BURST_BITS-1:0]     row_col;

    assign mul_w = frame_y8 * cfg.frame_full_width;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) stage <= '0;
        else      stage <= {stage[`CALC_LATENCY-3:0], recalc};
    end

    always_ff @(posedge rst) begin
        if (recalc) begin
            frame_x <= cfg.window_x0 + pos.curr_x;
            frame_y <= cfg.window_y0 + pos.curr_y;
        end
        if (stage[0]) begin
            frame_y8 <= frame_y[`FRAME_HEIGHT_BITS-1:3];
            bank     <= frame_y[2:0];  // 8 consecutive lines in 8 banks
        end
        if (stage[1]) mul_r <= mul_w[`NUM_RC_BURST_BITS-1:0];  // maps onto a DSP
        if (stage[2]) line_start <= cfg.start_addr + mul_r;
        if (stage[3]) row_col <= line_start + `NUM_RC_BURST_BITS'(frame_x);
        if (stage[`CALC_LATENCY-2]) addr <= {bank, row_col};  // row is the upper 15 bits
    end

endmodule

/* hdl/tiled_regs.sv */
`timescale 1ns/1ps
`include "tiled_config.svh"

module tiled_regs (
    input  logic                  rst,     // clock
    input  logic                  mclk,    // async reset
    input  tiled_pkg::cmd_t       cmd,
    output tiled_pkg::tiled_cfg_t cfg,
    output logic                  cfg_wr   // one cycle per accepted write
);
    logic lsw_zero;  // low word width field is 0
    logic msw_zero;  // high word is 0
    logic tw_zero;
    logic th_zero;
    logic tv_zero;

    assign lsw_zero = ~|cmd.data[`FRAME_WIDTH_BITS-1:0];
    assign msw_zero = ~|cmd.data[31:16];
    assign tw_zero  = ~|cmd.data[0+:`MAX_TILE_WIDTH];
    assign th_zero  = ~|cmd.data[8+:`MAX_TILE_HEIGHT];
    assign tv_zero  = ~|cmd.data[16+:`MAX_TILE_HEIGHT];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cfg    <= '0;
            cfg_wr <= 1'b0;
        end else begin
            cfg_wr <= cmd.wr;  // cleared below for unmapped addresses
            if (cmd.wr) begin
                case (cmd.addr)
                    `TILED_MODE: begin
                        cfg.reset_n     <= cmd.data[0];
                        cfg.enable      <= cmd.data[1];
                        cfg.extra_pages <= cmd.data[3:2];
                        cfg.keep_open   <= cmd.data[4];
                    end
                    `TILED_STARTADDR:        cfg.start_addr <= cmd.data[`NUM_RC_BURST_BITS-1:0];
                    `TILED_FRAME_FULL_WIDTH: begin
                        cfg.frame_full_width <= {lsw_zero, cmd.data[`FRAME_WIDTH_BITS-1:0]};
                    end
                    `TILED_WINDOW_WH: begin
                        cfg.window_width  <= {lsw_zero, cmd.data[`FRAME_WIDTH_BITS-1:0]};
                        cfg.window_height <= {msw_zero, cmd.data[`FRAME_HEIGHT_BITS+15:16]};
                    end
                    `TILED_WINDOW_X0Y0: begin
                        cfg.window_x0 <= cmd.data[`FRAME_WIDTH_BITS-1:0];
                        cfg.window_y0 <= cmd.data[`FRAME_HEIGHT_BITS+15:16];
                    end
                    `TILED_WINDOW_STARTXY: begin
                        cfg.start_x <= cmd.data[`FRAME_WIDTH_BITS-1:0];
                        cfg.start_y <= cmd.data[`FRAME_HEIGHT_BITS+15:16];
                    end
                    `TILED_TILE_WHS: begin
                        cfg.tile_cols  <= {tw_zero, cmd.data[0+:`MAX_TILE_WIDTH]};    // 0 -> 64
                        cfg.tile_rows  <= {th_zero, cmd.data[8+:`MAX_TILE_HEIGHT]};
                        cfg.tile_vstep <= {tv_zero, cmd.data[16+:`MAX_TILE_HEIGHT]};
                    end
                    default: cfg_wr <= 1'b0;
                endcase
            end
        end
    end

endmodule

/* hdl/tiled_pkg.sv */
`include "tiled_config.svh"

package tiled_pkg;

    typedef struct packed {
        logic        wr;    // write strobe
        logic [3:0]  addr;  // register address
        logic [31:0] data;
    } cmd_t;

    typedef struct packed {
        logic                            enable;
        logic                            reset_n;          // low holds the channel idle
        logic [1:0]                      extra_pages;      // client wants more pages buffered
        logic                            keep_open;        // keep banks open between rows
        logic [`NUM_RC_BURST_BITS-1:0]   start_addr;
        logic [`FRAME_WIDTH_BITS:0]      frame_full_width; // row/col step between frame lines
        logic [`FRAME_WIDTH_BITS:0]      window_width;
        logic [`FRAME_HEIGHT_BITS:0]     window_height;
        logic [`FRAME_WIDTH_BITS-1:0]    window_x0;
        logic [`FRAME_HEIGHT_BITS-1:0]   window_y0;
        logic [`FRAME_WIDTH_BITS-1:0]    start_x;          // relative to window left
        logic [`FRAME_HEIGHT_BITS-1:0]   start_y;          // relative to window top
        logic [`MAX_TILE_WIDTH:0]        tile_cols;
        logic [`MAX_TILE_HEIGHT:0]       tile_rows;
        logic [`MAX_TILE_HEIGHT:0]       tile_vstep;       // can be less than tile_rows for overlap
    } tiled_cfg_t;

    typedef struct packed {
        logic [`FRAME_WIDTH_BITS-1:0]  curr_x;  // transfer start, window relative
        logic [`FRAME_HEIGHT_BITS-1:0] curr_y;
    } tile_pos_t;

    typedef struct packed {
        logic [2:0]                   bank;
        logic [`ADDRESS_NUMBER-1:0]   row;
        logic [`COLADDR_NUMBER-4:0]   col;   // in 8-bursts
    } tile_addr_t;

    typedef struct packed {
        logic [`MAX_TILE_WIDTH:0] span;         // tile width clipped at window edge
        logic                     last_in_row;
        logic                     last_row;
    } tile_span_t;

    typedef struct packed {
        tile_addr_t                  addr;
        logic [`MAX_TILE_WIDTH-1:0]  num_cols_m1;
        logic [`MAX_TILE_HEIGHT-1:0] num_rows_m1;
        logic [`FRAME_WIDTH_BITS:0]  rowcol_inc;   // added to {row, col} per scan line
        logic                        keep_open;
        logic                        partial;      // first half of a page-split tile
    } xfer_t;

endpackage

/* hdl/tiled_config.svh */
`ifndef TILED_CONFIG_SVH
`define TILED_CONFIG_SVH

`define ADDRESS_NUMBER      15   // row address bits
`define COLADDR_NUMBER      10   // column bits, 3 LSBs dropped for 8-bursts
`define FRAME_WIDTH_BITS    13   // frame width in 8-bursts
`define FRAME_HEIGHT_BITS   16   // frame height in lines
`define MAX_TILE_WIDTH      6    // tile width field, 0 means 64
`define MAX_TILE_HEIGHT     6    // tile height field, 0 means 64
`define NUM_RC_BURST_BITS   22   // combined {row, col8}
`define CALC_LATENCY        6    // recalc pulse to valid address and span

// register addresses on the write port
`define TILED_MODE             4'h0  // {keep_open, extra_pages[1:0], enable, reset_n}
`define TILED_STARTADDR        4'h2  // frame start in {row, col8}, bank 0
`define TILED_FRAME_FULL_WIDTH 4'h3  // padded line length in 8-bursts
`define TILED_WINDOW_WH        4'h4  // {height, width}
`define TILED_WINDOW_X0Y0      4'h5  // {top, left}
`define TILED_WINDOW_STARTXY   4'h6  // {start y, start x} inside the window
`define TILED_TILE_WHS         4'h7  // {vstep, height, width} one byte each

`endif
